/* include/nb_fetch_params.svh */
/*
 * Neighborhood fetch sizes
 * Frame geometry, field widths and the feature table base address
 */
`ifndef NB_FETCH_PARAMS_SVH
`define NB_FETCH_PARAMS_SVH

// Frame size in tiles
`define NB_TILES_X 20
`define NB_TILES_Y 12

// Tile coordinate widths
`define NB_ROW_W 4
`define NB_COL_W 5

// Feature word and tag widths
`define NB_FEAT_W 32
`define NB_TAG_W 8
// Low tag bits hold the tap index
`define NB_IDX_W 4

// Word address of tile (0,0)
`define NB_ADDR_W 16
`define NB_BASE_ADDR 16'h0100

`endif

/* logic/nb_fetch_pkg.sv */
/*
 * Neighborhood fetch types
 * Scheduler states, tap codes and the request, memory and bundle structs
 */
`default_nettype none
`include "nb_fetch_params.svh"

package nb_fetch_pkg;

  // Scheduler states
  typedef enum logic [1:0] {
    idle  = 0,
    issue = 1,
    drain = 2
  } nb_state_e;

  // Taps in row-major order, center is tap_c
  typedef enum logic [`NB_IDX_W-1:0] {
    tap_nw = 0,
    tap_n  = 1,
    tap_ne = 2,
    tap_w  = 3,
    tap_c  = 4,
    tap_e  = 5,
    tap_sw = 6,
    tap_s  = 7,
    tap_se = 8
  } nb_tap_e;

  typedef struct packed {
    logic [`NB_ROW_W-1:0] row;
    logic [`NB_COL_W-1:0] col;
  } tile_coord_t;

  typedef struct packed {
    tile_coord_t          coord;
    logic [`NB_TAG_W-1:0] tag;
  } center_req_t;

  typedef struct packed {
    logic [`NB_ADDR_W-1:0] addr;
    logic [`NB_TAG_W-1:0]  tag;
  } mem_req_t;

  typedef struct packed {
    logic [`NB_FEAT_W-1:0] data;
    logic [`NB_TAG_W-1:0]  tag;
  } mem_rsp_t;

  // kv[k] is tap k, group tag drops the tap index bits
  typedef struct packed {
    logic [8:0][`NB_FEAT_W-1:0]   kv;
    logic [`NB_TAG_W-1:`NB_IDX_W] group_tag;
  } nb_bundle_t;

endpackage

`default_nettype wire

/* logic/nb_tap_counter.sv */
/*
 * Tap counter
 * Tracks issued reads and returned words over the nine taps of a center
 */
`timescale 1ns/1ns
`default_nettype none
`include "nb_fetch_params.svh"

module nb_tap_counter import nb_fetch_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    clear,
  input  logic    issue_en,
  input  logic    mem_rvalid,
  output nb_tap_e issue_idx,
  output logic    issue_last,
  output logic    ret_last
);

  // Next tap to issue and count of returns so far
  logic [`NB_IDX_W-1:0] issue_cnt;
  logic [`NB_IDX_W-1:0] ret_cnt;
  // Set once tap_se has been accepted
  logic                 issue_done;

  assign issue_idx  = nb_tap_e'(issue_cnt);
  assign issue_last = (issue_cnt == tap_se);
  // Ninth return of this center
  assign ret_last   = mem_rvalid && (ret_cnt == tap_se);

  // Issue side
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      issue_cnt  <= '0;
      issue_done <= 1'b0;
    end else if (issue_en) begin
      if (issue_last) begin
        issue_done <= 1'b1;
      end else begin
        issue_cnt <= issue_cnt + 1'b1;
      end
    end
  end

  // Return side, wraps after the ninth word
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      ret_cnt <= '0;
    end else if (mem_rvalid) begin
      ret_cnt <= ret_last ? '0 : ret_cnt + 1'b1;
    end
  end

  // Every return needs an outstanding read
  a_ret_le_issue: assert property (@(posedge clk) disable iff (rst)
    mem_rvalid |-> (issue_done || (ret_cnt < issue_cnt)));

endmodule

`default_nettype wire

/* logic/nb_fetch_sched.sv */
/*
 * Fetch scheduler
 * Accepts a center, issues its nine reads and waits for all returns
 */
`timescale 1ns/1ns
`default_nettype none

module nb_fetch_sched import nb_fetch_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        center_valid,
  input  center_req_t center_req,
  input  logic        mem_rd_ready,
  input  logic        collect_free,
  input  logic        issue_last,
  input  logic        ret_last,
  output logic        center_ready,
  output center_req_t center_q,
  output logic        mem_rd_valid,
  output logic        issue_en,
  output logic        clear,
  output logic        sched_busy,
  output logic        sched_done_pulse
);

  nb_state_e state;
  nb_state_e nxt_state;
  // Registered copy of state == idle, low during reset
  logic      idle_q;
  logic      center_fire;

  // --------------------
  // Handshakes
  // --------------------

  // Next center only once the collect buffer has drained
  assign center_ready = idle_q && collect_free;
  assign center_fire  = center_valid && center_ready;
  // New center restarts the tap counters
  assign clear        = center_fire;

  // Read valid held through the whole issue phase
  assign mem_rd_valid = (state == issue);
  assign issue_en     = mem_rd_valid && mem_rd_ready;

  // Status
  assign sched_busy       = (state != idle);
  assign sched_done_pulse = (state == drain) && ret_last;

  // --------------------
  // State machine
  // --------------------

  always_comb begin
    nxt_state = state;
    case (state)
      idle: begin
        if (center_fire) begin
          nxt_state = issue;
        end
      end
      issue: begin
        // Last tap accepted
        if (issue_en && issue_last) begin
          nxt_state = drain;
        end
      end
      drain: begin
        if (ret_last) begin
          nxt_state = idle;
        end
      end
      default: nxt_state = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= idle;
      idle_q <= 1'b0;
    end else begin
      state  <= nxt_state;
      idle_q <= (nxt_state == idle);
    end
  end

  // Center held for the address generator
  always_ff @(posedge clk) begin
    if (center_fire) begin
      center_q <= center_req;
    end
  end

  // Accepted center starts issuing on the next cycle
  a_accept_idle: assert property (@(posedge clk) disable iff (rst)
    center_fire |-> !sched_busy ##1 (sched_busy && mem_rd_valid));

  // Pending read stays in issue with a stable center
  a_rd_hold: assert property (@(posedge clk) disable iff (rst)
    (mem_rd_valid && !mem_rd_ready) |=>
      (state == issue) && mem_rd_valid && $stable(center_q));

endmodule

`default_nettype wire

/* logic/nb_tap_addr_gen.sv */
/*
 * Tap address generator
 * Clamped tile address and tag for the current tap, plus center flags
 */
`timescale 1ns/1ns
`default_nettype none
`include "nb_fetch_params.svh"

module nb_tap_addr_gen import nb_fetch_pkg::*; (
  input  center_req_t center_q,
  input  nb_tap_e     issue_idx,
  output mem_req_t    mem_req,
  output logic [8:0]  nb_is_center
);

  // Clamped tile of every tap
  tile_coord_t taps [9];
  tile_coord_t cur;

  // Apply the tap offset and clamp to the frame
  function automatic tile_coord_t clamp_tap(tile_coord_t c, logic [`NB_IDX_W-1:0] k);
    logic signed [`NB_ROW_W+1:0] r;
    logic signed [`NB_COL_W+1:0] q;
    tile_coord_t                 t;
    r = $signed({2'b00, c.row});
    q = $signed({2'b00, c.col});
    // Row offset from the tap row
    if (k < 3) begin
      r = r - 1;
    end else if (k > 5) begin
      r = r + 1;
    end
    // Column offset from the tap column
    case (k)
      0, 3, 6: q = q - 1;
      2, 5, 8: q = q + 1;
      default: q = q;
    endcase
    // Edge tiles replicate
    if (r < 0) begin
      t.row = '0;
    end else if (r > `NB_TILES_Y - 1) begin
      t.row = `NB_ROW_W'(`NB_TILES_Y - 1);
    end else begin
      t.row = r[`NB_ROW_W-1:0];
    end
    if (q < 0) begin
      t.col = '0;
    end else if (q > `NB_TILES_X - 1) begin
      t.col = `NB_COL_W'(`NB_TILES_X - 1);
    end else begin
      t.col = q[`NB_COL_W-1:0];
    end
    return t;
  endfunction

  always_comb begin
    for (int k = 0; k < 9; k++) begin
      taps[k]         = clamp_tap(center_q.coord, `NB_IDX_W'(k));
      nb_is_center[k] = (taps[k] == center_q.coord);
    end
  end

  assign cur = taps[issue_idx];

  // Row-major word address from the base
  assign mem_req.addr = `NB_ADDR_W'(`NB_BASE_ADDR)
                      + `NB_ADDR_W'(cur.row) * `NB_ADDR_W'(`NB_TILES_X)
                      + `NB_ADDR_W'(cur.col);
  // Group bits of the center tag, tap index below
  assign mem_req.tag  = {center_q.tag[`NB_TAG_W-1:`NB_IDX_W], issue_idx};

endmodule

`default_nettype wire

/* logic/nb_bundle_assembler.sv */
/*
 * Bundle assembler
 * Collects nine returns by tap index and hands the bundle to an output register
 */
`timescale 1ns/1ns
`default_nettype none
`include "nb_fetch_params.svh"

module nb_bundle_assembler import nb_fetch_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  mem_rvalid,
  input  mem_rsp_t              mem_rsp,
  input  logic                  out_ready,
  output logic                  collect_free,
  output logic                  out_valid,
  output nb_bundle_t            bundle,
  output logic [`NB_FEAT_W-1:0] q_vec
);

  // Collect buffer
  logic [8:0][`NB_FEAT_W-1:0]   coll_kv;
  logic [8:0][`NB_FEAT_W-1:0]   coll_kv_nxt;
  logic [`NB_TAG_W-1:`NB_IDX_W] coll_grp;
  logic [`NB_TAG_W-1:`NB_IDX_W] coll_grp_nxt;
  // One bit per filled slot
  logic [8:0]                   filled;
  logic [8:0]                   filled_nxt;
  logic [8:0]                   ret_bit;
  logic [`NB_IDX_W-1:0]         ret_idx;
  logic                         coll_full;
  logic                         out_open;
  logic                         move;

  // Tap index from the return tag
  assign ret_idx = mem_rsp.tag[`NB_IDX_W-1:0];

  // --------------------
  // Collect side
  // --------------------

  // Buffer contents with this cycle's return merged in
  always_comb begin
    coll_kv_nxt  = coll_kv;
    coll_grp_nxt = coll_grp;
    ret_bit      = '0;
    if (mem_rvalid) begin
      coll_kv_nxt[ret_idx] = mem_rsp.data;
      coll_grp_nxt         = mem_rsp.tag[`NB_TAG_W-1:`NB_IDX_W];
      ret_bit[ret_idx]     = 1'b1;
    end
  end

  assign filled_nxt = filled | ret_bit;
  assign coll_full  = &filled_nxt;
  // Output register empty or emptied this cycle
  assign out_open   = !out_valid || out_ready;
  // Ninth word bypasses straight to the output when it can
  assign move       = coll_full && out_open;

  assign collect_free = (filled == '0);

  always_ff @(posedge clk) begin
    coll_kv  <= coll_kv_nxt;
    coll_grp <= coll_grp_nxt;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      filled <= '0;
    end else if (move) begin
      filled <= '0;
    end else begin
      filled <= filled_nxt;
    end
  end

  // --------------------
  // Output register
  // --------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (move) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (move) begin
      bundle.kv        <= coll_kv_nxt;
      bundle.group_tag <= coll_grp_nxt;
    end
  end

  // Query is the center tap
  assign q_vec = bundle.kv[tap_c];

  // Each slot written once per center
  a_slot_free: assert property (@(posedge clk) disable iff (rst)
    mem_rvalid |-> (ret_idx <= tap_se) && !filled[ret_idx]);

  // Held bundle under back-pressure
  a_out_hold: assert property (@(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> out_valid && $stable(bundle));

endmodule

`default_nettype wire

/* logic/nb_fetch_bundle_top.sv */
/*
 * Neighborhood fetch top
 * Joins the scheduler, tap counter and address generator to the bundle assembler
 */
`timescale 1ns/1ns
`default_nettype none
`include "nb_fetch_params.svh"

module nb_fetch_bundle_top import nb_fetch_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  // Center request
  input  logic                  center_valid,
  output logic                  center_ready,
  input  center_req_t           center_req,
  // Read command
  output logic                  mem_rd_valid,
  input  logic                  mem_rd_ready,
  output mem_req_t              mem_req,
  // Read return, always accepted
  input  logic                  mem_rvalid,
  input  mem_rsp_t              mem_rsp,
  // Bundle
  output logic                  out_valid,
  input  logic                  out_ready,
  output nb_bundle_t            bundle,
  output logic [`NB_FEAT_W-1:0] q_vec,
  // Status
  output logic                  sched_busy,
  output logic                  sched_done_pulse,
  output logic                  bundle_done_pulse,
  output logic [8:0]            nb_is_center
);

  center_req_t center_q;
  nb_tap_e     issue_idx;
  logic        issue_en;
  logic        issue_last;
  logic        ret_last;
  logic        clear;
  logic        collect_free;

  nb_fetch_sched u_sched (
    .clk              (clk),
    .rst              (rst),
    .center_valid     (center_valid),
    .center_req       (center_req),
    .mem_rd_ready     (mem_rd_ready),
    .collect_free     (collect_free),
    .issue_last       (issue_last),
    .ret_last         (ret_last),
    .center_ready     (center_ready),
    .center_q         (center_q),
    .mem_rd_valid     (mem_rd_valid),
    .issue_en         (issue_en),
    .clear            (clear),
    .sched_busy       (sched_busy),
    .sched_done_pulse (sched_done_pulse)
  );

  nb_tap_counter u_counter (
    .clk        (clk),
    .rst        (rst),
    .clear      (clear),
    .issue_en   (issue_en),
    .mem_rvalid (mem_rvalid),
    .issue_idx  (issue_idx),
    .issue_last (issue_last),
    .ret_last   (ret_last)
  );

  nb_tap_addr_gen u_addr (
    .center_q     (center_q),
    .issue_idx    (issue_idx),
    .mem_req      (mem_req),
    .nb_is_center (nb_is_center)
  );

  nb_bundle_assembler u_bundle (
    .clk          (clk),
    .rst          (rst),
    .mem_rvalid   (mem_rvalid),
    .mem_rsp      (mem_rsp),
    .out_ready    (out_ready),
    .collect_free (collect_free),
    .out_valid    (out_valid),
    .bundle       (bundle),
    .q_vec        (q_vec)
  );

  // Bundle consumed
  assign bundle_done_pulse = out_valid && out_ready;

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
/*
 * Testbench clock source
 * Free-running clock, 4 ns period
 */
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
  output logic clk
);

  // Half of the 4 ns period
  localparam int HALF_PERIOD = 2;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

endmodule

`default_nettype wire

/* dv/nb_fetch_bundle_tb.sv */
/*
 * Neighborhood fetch testbench
 * Random centers, a variable-latency memory model and a bundle reference model
 */
`timescale 1ns/1ns
`default_nettype none
`include "nb_fetch_params.svh"

module nb_fetch_bundle_tb import nb_fetch_pkg::*; ();

  localparam int NUM_CENTERS    = 200;
  localparam int TIMEOUT_CYCLES = NUM_CENTERS * 60;
  // Idle cycles at the end to catch stray bundles
  localparam int TAIL_CYCLES    = 40;

  logic                  clk;
  logic                  rst;
  logic                  center_valid;
  logic                  center_ready;
  center_req_t           center_req;
  logic                  mem_rd_valid;
  logic                  mem_rd_ready;
  mem_req_t              mem_req;
  logic                  mem_rvalid;
  mem_rsp_t              mem_rsp;
  logic                  out_valid;
  logic                  out_ready;
  nb_bundle_t            bundle;
  logic [`NB_FEAT_W-1:0] q_vec;
  logic                  sched_busy;
  logic                  sched_done_pulse;
  logic                  bundle_done_pulse;
  logic [8:0]            nb_is_center;

  integer     seed;
  // Reference model and memory model state
  mem_req_t   exp_rd_q[$];
  nb_bundle_t exp_bundle_q[$];
  mem_rsp_t   mem_pend_q[$];
  int         mem_due_q[$];
  logic [8:0] exp_is_center;
  nb_bundle_t held_bundle;
  logic       hold_prev;
  logic       center_taken;
  int         cyc;
  int         last_due;
  int         n_sent;
  int         n_accepted;
  int         n_sched_done;
  int         n_bundle_done;
  int         timeout_cnt = 0;

  tb_clk_gen clk_gen_i (
    .clk (clk)
  );

  nb_fetch_bundle_top nb_fetch_bundle_top_i (
    .clk               (clk),
    .rst               (rst),
    .center_valid      (center_valid),
    .center_ready      (center_ready),
    .center_req        (center_req),
    .mem_rd_valid      (mem_rd_valid),
    .mem_rd_ready      (mem_rd_ready),
    .mem_req           (mem_req),
    .mem_rvalid        (mem_rvalid),
    .mem_rsp           (mem_rsp),
    .out_valid         (out_valid),
    .out_ready         (out_ready),
    .bundle            (bundle),
    .q_vec             (q_vec),
    .sched_busy        (sched_busy),
    .sched_done_pulse  (sched_done_pulse),
    .bundle_done_pulse (bundle_done_pulse),
    .nb_is_center      (nb_is_center)
  );

  // --------------------
  // Reporting
  // --------------------

  task automatic stop_with_failure();
    $display("*** FAILED ***");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_problem(input string why);
    $display("%s", why);
    stop_with_failure();
  endtask

  task automatic check_value(input string name, input logic [319:0] act,
                             input logic [319:0] exp);
    if (act !== exp) begin
      $display("error: %s actual 0x%0h expected 0x%0h", name, act, exp);
      stop_with_failure();
    end
  endtask

  // Run limit from the number of centers
  always @(posedge clk) begin
    timeout_cnt = timeout_cnt + 1;
    if (timeout_cnt > TIMEOUT_CYCLES) begin
      report_problem($sformatf("timeout: run did not finish in %0d cycles", TIMEOUT_CYCLES));
    end
  end

  // --------------------
  // Models
  // --------------------

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % 32'(n));
  endfunction

  // Feature word stored at a word address
  function automatic logic [`NB_FEAT_W-1:0] feature_hash(input logic [`NB_ADDR_W-1:0] addr);
    logic [31:0] h;
    h = 32'(addr) * 32'h9e37_79b1;
    h = h ^ (h >> 13) ^ 32'h5bd1_e995;
    return h;
  endfunction

  function automatic int clamp_range(input int v, input int hi);
    if (v < 0) begin
      return 0;
    end
    if (v > hi) begin
      return hi;
    end
    return v;
  endfunction

  // Nine expected reads and one expected bundle per accepted center
  task automatic expect_center(input center_req_t c);
    nb_bundle_t b;
    mem_req_t   rd;
    int         r;
    int         q;
    int         addr;
    for (int k = 0; k < 9; k++) begin
      // Row offset from k / 3, column offset from k % 3
      r = clamp_range(int'(c.coord.row) + k / 3 - 1, `NB_TILES_Y - 1);
      q = clamp_range(int'(c.coord.col) + k % 3 - 1, `NB_TILES_X - 1);
      addr = int'(`NB_BASE_ADDR) + r * `NB_TILES_X + q;
      rd.addr = `NB_ADDR_W'(addr);
      rd.tag  = {c.tag[`NB_TAG_W-1:`NB_IDX_W], `NB_IDX_W'(k)};
      exp_rd_q.push_back(rd);
      b.kv[k] = feature_hash(rd.addr);
      exp_is_center[k] = (r == int'(c.coord.row)) && (q == int'(c.coord.col));
    end
    b.group_tag = c.tag[`NB_TAG_W-1:`NB_IDX_W];
    exp_bundle_q.push_back(b);
  endtask

  task automatic make_center();
    center_req_t c;
    int          sel;
    c.coord.row = `NB_ROW_W'(rand_below(`NB_TILES_Y));
    c.coord.col = `NB_COL_W'(rand_below(`NB_TILES_X));
    c.tag       = `NB_TAG_W'(rand_below(256));
    // Every eighth request goes to a corner or an edge
    if (n_sent % 8 == 0) begin
      sel = rand_below(8);
      case (sel)
        0, 1, 4: c.coord.row = '0;
        2, 3, 5: c.coord.row = `NB_ROW_W'(`NB_TILES_Y - 1);
        default: c.coord.row = c.coord.row;
      endcase
      case (sel)
        0, 2, 6: c.coord.col = '0;
        1, 3, 7: c.coord.col = `NB_COL_W'(`NB_TILES_X - 1);
        default: c.coord.col = c.coord.col;
      endcase
    end
    center_req = c;
  endtask

  // --------------------
  // Per-cycle sampling and driving
  // --------------------

  // Handshakes as seen at this rising edge
  task automatic sample_outputs();
    mem_req_t   rd;
    mem_rsp_t   rsp;
    nb_bundle_t b;
    int         due;
    // Bundle held since the last edge
    if (hold_prev) begin
      check_value("out_valid", out_valid, 1'b1);
      check_value("bundle", bundle, held_bundle);
    end
    hold_prev   = out_valid && !out_ready;
    held_bundle = bundle;
    center_taken = center_valid && center_ready;
    if (center_taken) begin
      check_value("sched_busy", sched_busy, 1'b0);
      expect_center(center_req);
      n_accepted++;
    end
    if (mem_rd_valid) begin
      check_value("nb_is_center", nb_is_center, exp_is_center);
    end
    if (mem_rd_valid && mem_rd_ready) begin
      if (exp_rd_q.size() == 0) begin
        report_problem("read issued with no center outstanding");
      end else begin
        rd = exp_rd_q.pop_front();
        check_value("mem_req.addr", mem_req.addr, rd.addr);
        check_value("mem_req.tag", mem_req.tag, rd.tag);
        // In-order return after 1 to 4 cycles
        due = cyc + 1 + rand_below(4);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        rsp.data = feature_hash(mem_req.addr);
        rsp.tag  = mem_req.tag;
        mem_pend_q.push_back(rsp);
        mem_due_q.push_back(due);
      end
    end
    if (out_valid && out_ready) begin
      if (exp_bundle_q.size() == 0) begin
        report_problem("bundle delivered with no center outstanding");
      end else begin
        b = exp_bundle_q.pop_front();
        for (int k = 0; k < 9; k++) begin
          check_value($sformatf("bundle.kv[%0d]", k), bundle.kv[k], b.kv[k]);
        end
        check_value("bundle.group_tag", bundle.group_tag, b.group_tag);
        check_value("q_vec", q_vec, b.kv[tap_c]);
      end
    end
    if (bundle_done_pulse) begin
      n_bundle_done++;
    end
    if (sched_done_pulse) begin
      n_sched_done++;
    end
  endtask

  task automatic drive_inputs();
    if (center_taken) begin
      center_valid = 1'b0;
    end
    // Center held until accepted, random gaps in between
    if (!center_valid && n_sent < NUM_CENTERS && rand_below(4) != 0) begin
      make_center();
      center_valid = 1'b1;
      n_sent++;
    end
    mem_rd_ready = (rand_below(4) != 0);
    out_ready    = (rand_below(3) != 0);
    mem_rvalid   = 1'b0;
    mem_rsp      = '0;
    if (mem_due_q.size() != 0 && mem_due_q[0] <= cyc) begin
      mem_rvalid = 1'b1;
      mem_rsp    = mem_pend_q.pop_front();
      void'(mem_due_q.pop_front());
    end
  endtask

  task automatic run_cycle();
    @(posedge clk);
    cyc++;
    sample_outputs();
    #1;
    drive_inputs();
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    seed          = 23167;
    rst           = 1'b1;
    center_valid  = 1'b0;
    center_req    = '0;
    mem_rd_ready  = 1'b0;
    mem_rvalid    = 1'b0;
    mem_rsp       = '0;
    out_ready     = 1'b0;
    exp_is_center = '0;
    hold_prev     = 1'b0;
    center_taken  = 1'b0;
    cyc           = 0;
    last_due      = 0;
    n_sent        = 0;
    n_accepted    = 0;
    n_sched_done  = 0;
    n_bundle_done = 0;

    // Five reset cycles, outputs quiet
    repeat (5) @(posedge clk);
    check_value("center_ready", center_ready, 1'b0);
    check_value("mem_rd_valid", mem_rd_valid, 1'b0);
    check_value("out_valid", out_valid, 1'b0);
    check_value("sched_busy", sched_busy, 1'b0);
    check_value("sched_done_pulse", sched_done_pulse, 1'b0);
    check_value("bundle_done_pulse", bundle_done_pulse, 1'b0);
    #1;
    rst = 1'b0;
    @(posedge clk);
    #1;
    // Ready in the first cycle out of reset
    @(posedge clk);
    check_value("center_ready", center_ready, 1'b1);
    #1;

    while (n_accepted < NUM_CENTERS || exp_bundle_q.size() != 0) begin
      run_cycle();
    end
    repeat (TAIL_CYCLES) run_cycle();

    // Nothing lost, nothing extra
    check_value("outstanding reads", exp_rd_q.size(), 0);
    check_value("sched_done_pulse count", n_sched_done, n_accepted);
    check_value("bundle_done_pulse count", n_bundle_done, n_accepted);

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+include
logic/nb_fetch_pkg.sv
logic/nb_tap_counter.sv
logic/nb_fetch_sched.sv
logic/nb_tap_addr_gen.sv
logic/nb_bundle_assembler.sv
logic/nb_fetch_bundle_top.sv
dv/tb_clk_gen.sv
dv/nb_fetch_bundle_tb.sv

/* Makefile */
# Verilator build and run for the neighborhood fetch testbench

VERILATOR ?= verilator
TOP       ?= nb_fetch_bundle_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

SOURCES := $(FILELIST) $(wildcard logic/*.sv dv/*.sv include/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run build lint clean

all: run

build: $(BIN)

$(BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	-./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then echo "simulation incomplete"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
